/* logic/calc_pkg.sv */
// Shared types for the calculator controller; IDs must stay below 32 and codes above 15 are letters
package calc_pkg;

  // ========================================
  // Operation and operand types
  // ========================================
  typedef enum logic [2:0] {
    OP_NONE,
    OP_ADD,
    OP_MAT_MUL,
    OP_SCALAR_MUL,
    OP_TRANSPOSE,
    OP_CONV
  } op_code_t;

  typedef logic [5:0] mat_id_t;         // Row field 5:3, column field 2:0
  typedef logic [2:0] dim_t;            // Row or column count
  typedef logic signed [7:0] elem_t;    // Element / scalar, two's complement

  localparam int MAT_TOTAL_SLOTS = 32;  // Valid ID bytes are 0..31

  // ========================================
  // Seven-segment digit codes
  // ========================================
  typedef logic [4:0] code_t;           // 0..15 plain hex digit

  localparam code_t CHAR_BLK  = 5'd16;
  localparam code_t CHAR_A    = 5'd17;
  localparam code_t CHAR_B    = 5'd18;  // Lower case b on the glass
  localparam code_t CHAR_C    = 5'd19;
  localparam code_t CHAR_T    = 5'd20;
  localparam code_t CHAR_J    = 5'd21;
  localparam code_t CHAR_E    = 5'd22;
  localparam code_t CHAR_R    = 5'd23;
  localparam code_t CHAR_Y    = 5'd24;
  localparam code_t CHAR_L    = 5'd25;
  localparam code_t CHAR_DASH = 5'd26;

  // What the display is showing right now
  typedef enum logic [2:0] {
    DISP_BLANK,
    DISP_OP,
    DISP_IDS,
    DISP_SCALAR,
    DISP_ERR,
    DISP_CYCLES
  } disp_phase_t;

endpackage

/* logic/user_input_frontend.sv */
// Buttons must already be debounced and synchronous; rx_done is a one-cycle strobe
`timescale 1ns/1ns

module user_input_frontend import calc_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     btn_confirm,
  input  logic     btn_esc,
  input  logic [7:0] rx_data,
  input  logic     rx_done,
  output logic     confirm_evt,
  output logic     esc_evt,
  output logic     op_evt,
  output op_code_t op_sel,
  output logic     id_evt,
  output mat_id_t  id_val
);

  logic     confirm_prev;  // Last sampled button levels
  logic     esc_prev;
  op_code_t rx_op;         // Letter decode of current byte

  // Upper and lower case both accepted
  function automatic op_code_t decode_letter(input logic [7:0] ch);
    case (ch)
      8'h41, 8'h61: return OP_ADD;        // A / a
      8'h42, 8'h62: return OP_MAT_MUL;    // B / b
      8'h43, 8'h63: return OP_SCALAR_MUL; // C / c
      8'h54, 8'h74: return OP_TRANSPOSE;  // T / t
      8'h4A, 8'h6A: return OP_CONV;       // J / j
      default:      return OP_NONE;
    endcase
  endfunction

  assign rx_op = decode_letter(rx_data);

  // Event strobes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      confirm_prev <= 1'b0;
      esc_prev     <= 1'b0;
      confirm_evt  <= 1'b0;
      esc_evt      <= 1'b0;
      op_evt       <= 1'b0;
      id_evt       <= 1'b0;
    end else begin
      confirm_prev <= btn_confirm;
      esc_prev     <= btn_esc;
      confirm_evt  <= btn_confirm & ~confirm_prev;  // Rising edge only
      esc_evt      <= btn_esc & ~esc_prev;
      op_evt       <= rx_done && (rx_op != OP_NONE);
      id_evt       <= rx_done && (rx_data < MAT_TOTAL_SLOTS); // Raw binary ID
    end
  end

  // Payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    op_sel <= rx_op;
    id_val <= rx_data[5:0];
  end

  // Letters sit above 0x40, so a byte can never be both
  a_evt_onehot: assert property (@(posedge clk) disable iff (!rst_n) !(op_evt && id_evt));

endmodule

/* logic/calc_sequencer.sv */
// Dimension inputs must follow id_a / id_b combinationally; one ALU job at a time
`timescale 1ns/1ns

module calc_sequencer import calc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_en,
  input  logic        confirm_evt,
  input  logic        esc_evt,
  input  logic        op_evt,
  input  op_code_t    op_sel,
  input  logic        id_evt,
  input  mat_id_t     id_val,
  input  logic [7:0]  scalar_val_in,   // Sign-magnitude from switches
  input  dim_t        mat_a_rows,
  input  dim_t        mat_a_cols,
  input  dim_t        mat_b_rows,
  input  dim_t        mat_b_cols,
  input  logic        exec_done,
  input  logic        exec_err,
  input  logic        cd_expired,
  output logic        exec_start,
  output logic        cd_load,
  output logic        cd_run,
  output op_code_t    op_reg,
  output mat_id_t     id_a,
  output mat_id_t     id_b,
  output elem_t       scalar_sm,
  output elem_t       alu_scalar,
  output disp_phase_t disp_phase,
  output logic        calc_sys_done,
  output logic        calc_err
);

  typedef enum logic [2:0] {
    IDLE, SELECT_OP, WAIT_ID_A, WAIT_ID_B, CONFIRM, EXEC, ERROR_WAIT, DONE_WAIT
  } seq_state_t;

  seq_state_t state;
  logic       dims_valid;  // Operand check for current op

  // Add needs equal shapes, multiply needs inner dims equal
  function automatic logic check_dims(input op_code_t op, input dim_t ar, input dim_t ac,
                                      input dim_t br, input dim_t bc);
    case (op)
      OP_ADD:     return (ar == br) && (ac == bc);
      OP_MAT_MUL: return (ac == br);
      default:    return 1'b1;
    endcase
  endfunction

  // Sign-magnitude to two's complement
  function automatic elem_t sm_to_tc(input logic [7:0] sm);
    logic [7:0] mag;
    mag = {1'b0, sm[6:0]};
    return sm[7] ? elem_t'(8'd0 - mag) : elem_t'(mag);
  endfunction

  assign dims_valid = check_dims(op_reg, mat_a_rows, mat_a_cols, mat_b_rows, mat_b_cols);
  assign cd_run     = (state == ERROR_WAIT);

  // ========================================
  // Main FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IDLE;
      op_reg        <= OP_NONE;
      id_a          <= '0;
      id_b          <= '0;
      scalar_sm     <= '0;
      alu_scalar    <= '0;
      exec_start    <= 1'b0;
      cd_load       <= 1'b0;
      calc_sys_done <= 1'b0;
      calc_err      <= 1'b0;
    end else begin
      exec_start    <= 1'b0;  // Strobes default low
      cd_load       <= 1'b0;
      calc_sys_done <= 1'b0;
      case (state)
        IDLE: if (start_en) begin
          op_reg <= OP_NONE;  // Dash until a letter arrives
          state  <= SELECT_OP;
        end
        SELECT_OP: begin
          if (esc_evt) begin
            calc_sys_done <= 1'b1;  // Leave calculator mode
            state         <= IDLE;
          end else if (op_evt) begin
            op_reg <= op_sel;
            state  <= WAIT_ID_A;
          end
        end
        WAIT_ID_A: begin
          if (esc_evt) state <= SELECT_OP;
          else if (id_evt) begin
            id_a <= id_val;
            if (op_reg == OP_CONV) id_b <= id_val;  // Kernel goes on both ports
            if (op_reg == OP_ADD || op_reg == OP_MAT_MUL) state <= WAIT_ID_B;
            else state <= CONFIRM;
          end
        end
        WAIT_ID_B: begin
          if (esc_evt) state <= SELECT_OP;
          else if (id_evt) begin
            id_b  <= id_val;
            state <= CONFIRM;
          end
        end
        CONFIRM: begin
          if (op_reg == OP_SCALAR_MUL) scalar_sm <= elem_t'(scalar_val_in); // Live preview
          if (esc_evt) state <= SELECT_OP;
          else if (confirm_evt) begin
            if (op_reg == OP_SCALAR_MUL) alu_scalar <= sm_to_tc(scalar_val_in);
            if (dims_valid) begin
              exec_start <= 1'b1;
              state      <= EXEC;
            end else begin
              calc_err <= 1'b1;
              cd_load  <= 1'b1;
              state    <= ERROR_WAIT;
            end
          end
        end
        EXEC: if (exec_done) begin
          if (exec_err) begin
            calc_err <= 1'b1;
            cd_load  <= 1'b1;
            state    <= ERROR_WAIT;
          end else begin
            state <= DONE_WAIT;
          end
        end
        ERROR_WAIT: begin
          if (id_evt) id_b <= id_val;  // Replacement operand B
          if (esc_evt || cd_expired) begin
            calc_err <= 1'b0;
            state    <= SELECT_OP;
          end else if (confirm_evt) begin
            if (dims_valid) begin
              calc_err   <= 1'b0;
              exec_start <= 1'b1;
              state      <= EXEC;
            end else begin
              cd_load <= 1'b1;  // Restart countdown
            end
          end
        end
        DONE_WAIT: if (confirm_evt || esc_evt) state <= SELECT_OP;
        default: state <= IDLE;
      endcase
    end
  end

  // Display phase per state
  always_comb begin
    case (state)
      SELECT_OP, WAIT_ID_A: disp_phase = DISP_OP;
      WAIT_ID_B, EXEC:      disp_phase = DISP_IDS;
      CONFIRM:    disp_phase = (op_reg == OP_SCALAR_MUL) ? DISP_SCALAR : DISP_IDS;
      ERROR_WAIT: disp_phase = DISP_ERR;
      DONE_WAIT:  disp_phase = DISP_CYCLES;
      default:    disp_phase = DISP_BLANK;
    endcase
  end

endmodule

/* logic/alu_link.sv */
// Four-phase master; exec_start must only come while idle with ack low
`timescale 1ns/1ns

module alu_link (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        exec_start,
  input  logic        alu_ack,
  input  logic        alu_err,
  input  logic [31:0] alu_cycle_cnt,
  output logic        alu_req,
  output logic        exec_done,
  output logic        exec_err,
  output logic [31:0] exec_cycles
);

  typedef enum logic [1:0] {L_IDLE, L_REQ, L_DROP} link_state_t;

  link_state_t state;

  // ========================================
  // Handshake FSM
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= L_IDLE;
      alu_req   <= 1'b0;
      exec_done <= 1'b0;
    end else begin
      exec_done <= 1'b0;
      case (state)
        L_IDLE: if (exec_start) begin
          alu_req <= 1'b1;  // Operands already stable
          state   <= L_REQ;
        end
        L_REQ: if (alu_ack) begin
          alu_req <= 1'b0;
          state   <= L_DROP;
        end
        L_DROP: if (!alu_ack) begin  // Slave released
          exec_done <= 1'b1;
          state     <= L_IDLE;
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  // Result sampled while ack is high
  always_ff @(posedge clk) begin
    if (state == L_REQ && alu_ack) begin
      exec_err    <= alu_err;
      exec_cycles <= alu_cycle_cnt;
    end
  end

  // Req held until the ALU answers
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    alu_req && !alu_ack |=> alu_req);
  // No new request over a stale ack
  a_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(alu_req) |-> !$past(alu_ack));

endmodule

/* logic/err_countdown.sv */
// Counts seconds of TICK_CYCLES clocks; load wins over run, expiry one tick after zero
`timescale 1ns/1ns

module err_countdown #(
  parameter int TICK_CYCLES = 100_000_000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cd_load,
  input  logic       cd_run,
  input  logic [3:0] cfg_err_countdown,
  output logic [3:0] cd_value,
  output logic       cd_expired
);

  localparam int PW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

  logic [PW-1:0] presc;     // Cycles within current second
  logic          tick;      // Last cycle of a second

  assign tick = (presc == PW'(TICK_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      presc      <= '0;
      cd_value   <= '0;
      cd_expired <= 1'b0;
    end else begin
      cd_expired <= 1'b0;
      if (cd_load) begin
        presc    <= '0;
        cd_value <= cfg_err_countdown;  // Fresh count
      end else if (!cd_run) begin
        presc <= '0;  // Idle, hold phase at zero
      end else if (tick) begin
        presc <= '0;
        if (cd_value != 4'd0) cd_value <= cd_value - 4'd1;
        else cd_expired <= 1'b1;
      end else begin
        presc <= presc + 1'b1;
      end
    end
  end

endmodule

/* logic/seg_formatter.sv */
// Digit 7 is leftmost; decimal fields show only the two low digits
`timescale 1ns/1ns

module seg_formatter import calc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  disp_phase_t disp_phase,
  input  op_code_t    op_reg,
  input  mat_id_t     id_a,
  input  mat_id_t     id_b,
  input  elem_t       scalar_sm,
  input  logic [3:0]  cd_value,
  input  logic [31:0] exec_cycles,
  output code_t [7:0] seg_data
);

  function automatic code_t op_letter(input op_code_t op);
    case (op)
      OP_ADD:        return CHAR_A;
      OP_MAT_MUL:    return CHAR_B;
      OP_SCALAR_MUL: return CHAR_C;
      OP_TRANSPOSE:  return CHAR_T;
      OP_CONV:       return CHAR_J;
      default:       return CHAR_DASH;  // Nothing picked yet
    endcase
  endfunction

  // Tens digit, wrapped to 0..9
  function automatic code_t dec_tens(input logic [6:0] v);
    logic [6:0] t;
    t = (v / 7'd10) % 7'd10;
    return code_t'(t);
  endfunction

  function automatic code_t dec_ones(input logic [6:0] v);
    logic [6:0] o;
    o = v % 7'd10;
    return code_t'(o);
  endfunction

  // ========================================
  // Digit builder
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg_data <= {8{CHAR_BLK}};
    end else begin
      case (disp_phase)
        DISP_OP:     seg_data <= {op_letter(op_reg), {7{CHAR_BLK}}};
        DISP_IDS:    seg_data <= {CHAR_A, CHAR_BLK, dec_tens({1'b0, id_a}), dec_ones({1'b0, id_a}),
                                  CHAR_B, CHAR_BLK, dec_tens({1'b0, id_b}), dec_ones({1'b0, id_b})};
        DISP_SCALAR: seg_data <= {CHAR_A, CHAR_BLK, dec_tens({1'b0, id_a}), dec_ones({1'b0, id_a}),
                                  CHAR_B, scalar_sm[7] ? CHAR_DASH : CHAR_BLK,  // Sign
                                  dec_tens(scalar_sm[6:0]), dec_ones(scalar_sm[6:0])};
        DISP_ERR:    seg_data <= {CHAR_B, CHAR_BLK, CHAR_E, CHAR_R, CHAR_R, CHAR_BLK,
                                  dec_tens({3'b0, cd_value}), dec_ones({3'b0, cd_value})};
        DISP_CYCLES: seg_data <= {CHAR_C, CHAR_Y, CHAR_C, CHAR_L,
                                  code_t'({1'b0, exec_cycles[15:12]}),
                                  code_t'({1'b0, exec_cycles[11:8]}),
                                  code_t'({1'b0, exec_cycles[7:4]}),
                                  code_t'({1'b0, exec_cycles[3:0]})};  // Low 16 bits hex
        default:     seg_data <= {8{CHAR_BLK}};
      endcase
    end
  end

endmodule

/* logic/calc_ctrl_top.sv */
// TICK_CYCLES is clocks per countdown second; mat_* dims must track alu_id_a / alu_id_b
`timescale 1ns/1ns

module calc_ctrl_top import calc_pkg::*; #(
  parameter int TICK_CYCLES = 100_000_000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start_en,
  input  logic        btn_confirm,
  input  logic        btn_esc,
  input  logic [7:0]  rx_data,
  input  logic        rx_done,
  input  logic [7:0]  scalar_val_in,
  input  dim_t        mat_a_rows,
  input  dim_t        mat_a_cols,
  input  dim_t        mat_b_rows,
  input  dim_t        mat_b_cols,
  input  logic [3:0]  cfg_err_countdown,
  input  logic        alu_ack,
  input  logic        alu_err,
  input  logic [31:0] alu_cycle_cnt,
  output logic        alu_req,
  output op_code_t    alu_op_code,
  output mat_id_t     alu_id_a,
  output mat_id_t     alu_id_b,
  output elem_t       alu_scalar,
  output logic        calc_sys_done,
  output logic        calc_err,
  output code_t [7:0] seg_data
);

  // ========================================
  // Internal links
  // ========================================
  logic        confirm_evt, esc_evt, op_evt, id_evt;  // Frontend strobes
  op_code_t    op_sel;
  mat_id_t     id_val;
  logic        exec_start, exec_done, exec_err;
  logic [31:0] exec_cycles;
  logic        cd_load, cd_run, cd_expired;
  logic [3:0]  cd_value;
  elem_t       scalar_sm;                             // Raw switch value for display
  disp_phase_t disp_phase;

  user_input_frontend i_user_input_frontend (
    .clk, .rst_n, .btn_confirm, .btn_esc, .rx_data, .rx_done,
    .confirm_evt, .esc_evt, .op_evt, .op_sel, .id_evt, .id_val
  );

  // Operand registers drive the ALU ports directly
  calc_sequencer i_calc_sequencer (
    .clk, .rst_n, .start_en, .confirm_evt, .esc_evt, .op_evt, .op_sel, .id_evt, .id_val,
    .scalar_val_in, .mat_a_rows, .mat_a_cols, .mat_b_rows, .mat_b_cols,
    .exec_done, .exec_err, .cd_expired, .exec_start, .cd_load, .cd_run,
    .op_reg(alu_op_code), .id_a(alu_id_a), .id_b(alu_id_b), .scalar_sm, .alu_scalar,
    .disp_phase, .calc_sys_done, .calc_err
  );

  alu_link i_alu_link (
    .clk, .rst_n, .exec_start, .alu_ack, .alu_err, .alu_cycle_cnt,
    .alu_req, .exec_done, .exec_err, .exec_cycles
  );

  err_countdown #(
    .TICK_CYCLES(TICK_CYCLES)
  ) i_err_countdown (
    .clk, .rst_n, .cd_load, .cd_run, .cfg_err_countdown, .cd_value, .cd_expired
  );

  seg_formatter i_seg_formatter (
    .clk, .rst_n, .disp_phase, .op_reg(alu_op_code), .id_a(alu_id_a), .id_b(alu_id_b),
    .scalar_sm, .cd_value, .exec_cycles, .seg_data
  );

endmodule

/* test/alu_responder.sv */
// Behavioral ALU slave; acks 1 to 8 clocks after req, error and count come from the testbench
`timescale 1ns/1ns

module alu_responder (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        alu_req,
  input  logic        err_val,        // Error flag for the next reply
  input  logic [31:0] cycles_val,     // Cycle count for the next reply
  output logic        alu_ack,
  output logic        alu_err,
  output logic [31:0] alu_cycle_cnt
);

  typedef enum logic [1:0] {R_IDLE, R_BUSY, R_ACK} resp_state_t;

  resp_state_t state;
  integer      seed = 32'he9e6;
  int          delay;                 // Remaining busy clocks

  // Slave moves on the falling edge, same as the stimulus
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= R_IDLE;
      delay         <= 0;
      alu_ack       <= 1'b0;
      alu_err       <= 1'b0;
      alu_cycle_cnt <= '0;
    end else begin
      case (state)
        R_IDLE: if (alu_req) begin
          delay <= $unsigned($random(seed)) % 8;  // Random latency
          state <= R_BUSY;
        end
        R_BUSY: begin
          if (delay == 0) begin
            alu_ack       <= 1'b1;
            alu_err       <= err_val;
            alu_cycle_cnt <= cycles_val;  // Valid while ack high
            state         <= R_ACK;
          end else begin
            delay <= delay - 1;
          end
        end
        R_ACK: if (!alu_req) begin
          alu_ack       <= 1'b0;  // Release, master sees done next
          alu_err       <= 1'b0;
          alu_cycle_cnt <= '0;
          state         <= R_IDLE;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

/* test/tb_calc_ctrl_top.sv */
// Matrix dims come from ID bits (rows 5:3, cols 2:0); TICK_CYCLES is 20 and the countdown is 2 s
`timescale 1ns/1ns

module tb_calc_ctrl_top import calc_pkg::*; ();

  localparam int TICK   = 20;
  localparam int CD_CFG = 2;

  // One expected ALU request
  typedef struct packed {
    op_code_t op;
    mat_id_t  a;
    mat_id_t  b;
    logic     chk_b;
    elem_t    sc;
    logic     chk_sc;
  } alu_exp_t;

  logic        clk = 1'b0;
  logic        rst_n, start_en, btn_confirm, btn_esc, rx_done;
  logic [7:0]  rx_data, scalar_val_in;
  dim_t        mat_a_rows, mat_a_cols, mat_b_rows, mat_b_cols;
  logic [3:0]  cfg_err_countdown;
  logic        alu_ack, alu_err, alu_req, calc_sys_done, calc_err;
  logic [31:0] alu_cycle_cnt;
  op_code_t    alu_op_code;
  mat_id_t     alu_id_a, alu_id_b;
  elem_t       alu_scalar;
  code_t [7:0] seg_data;

  integer      seed = 32'he9e6;
  int          errors = 0;
  int          checks = 0;
  int          cyc = 0;             // Clock counter for timing checks
  int          sys_done_count = 0;
  int          err_rise_cyc = 0;
  logic        req_seen = 1'b0;
  logic        err_seen = 1'b0;
  alu_exp_t    exp_q[$];            // Requests the DUT still owes
  logic        resp_err;
  logic [31:0] resp_cycles;
  mat_id_t     a, b;
  logic [7:0]  mag;
  int          t;

  always #4 clk = ~clk;
  always @(posedge clk) cyc <= cyc + 1;

  // Matrix store model: dims encoded in the slot ID
  assign mat_a_rows = alu_id_a[5:3];
  assign mat_a_cols = alu_id_a[2:0];
  assign mat_b_rows = alu_id_b[5:3];
  assign mat_b_cols = alu_id_b[2:0];

  calc_ctrl_top #(.TICK_CYCLES(TICK)) i_calc_ctrl_top (
    .clk, .rst_n, .start_en, .btn_confirm, .btn_esc, .rx_data, .rx_done, .scalar_val_in,
    .mat_a_rows, .mat_a_cols, .mat_b_rows, .mat_b_cols, .cfg_err_countdown,
    .alu_ack, .alu_err, .alu_cycle_cnt, .alu_req, .alu_op_code, .alu_id_a, .alu_id_b,
    .alu_scalar, .calc_sys_done, .calc_err, .seg_data
  );

  alu_responder i_alu_responder (
    .clk, .rst_n, .alu_req, .err_val(resp_err), .cycles_val(resp_cycles),
    .alu_ack, .alu_err, .alu_cycle_cnt
  );

  // ========================================
  // Reference model
  // ========================================
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  function automatic mat_id_t make_id(input int rows, input int cols);
    return mat_id_t'((rows << 3) | cols);  // Rows kept below 4, ID below 32
  endfunction

  function automatic logic ref_valid(input op_code_t op, input mat_id_t ia, input mat_id_t ib);
    if (op == OP_ADD) return int'(ia) == int'(ib);  // Same shape means same slot here
    if (op == OP_MAT_MUL) return (int'(ia) & 7) == (int'(ib) >> 3);
    return 1'b1;
  endfunction

  function automatic elem_t ref_scalar(input logic [7:0] sm);
    int m;
    m = int'(sm[6:0]);
    if (sm[7]) m = -m;  // Sign bit flips the magnitude
    return elem_t'(m);
  endfunction

  function automatic logic [39:0] ref_display(input disp_phase_t ph, input op_code_t op,
      input mat_id_t ia, input logic [7:0] sm, input int cd, input logic [31:0] cnt);
    code_t [7:0] d;
    int          m;
    d = {8{CHAR_BLK}};
    m = int'(sm[6:0]);
    case (ph)
      DISP_OP: begin
        case (op)
          OP_ADD:        d[7] = CHAR_A;
          OP_MAT_MUL:    d[7] = CHAR_B;
          OP_SCALAR_MUL: d[7] = CHAR_C;
          OP_TRANSPOSE:  d[7] = CHAR_T;
          OP_CONV:       d[7] = CHAR_J;
          default:       d[7] = CHAR_DASH;
        endcase
      end
      DISP_SCALAR: begin
        d[7] = CHAR_A;
        d[5] = code_t'(int'(ia) / 10 % 10);
        d[4] = code_t'(int'(ia) % 10);
        d[3] = CHAR_B;
        d[2] = sm[7] ? CHAR_DASH : CHAR_BLK;
        d[1] = code_t'(m / 10 % 10);
        d[0] = code_t'(m % 10);
      end
      DISP_ERR: begin
        d[7] = CHAR_B;
        d[5] = CHAR_E;
        d[4] = CHAR_R;
        d[3] = CHAR_R;
        d[1] = code_t'(cd / 10 % 10);
        d[0] = code_t'(cd % 10);
      end
      DISP_CYCLES: begin
        d[7:4] = {CHAR_C, CHAR_Y, CHAR_C, CHAR_L};
        for (int k = 0; k < 4; k++) d[k] = code_t'((cnt >> (4 * k)) & 32'hf);
      end
      default: d = {8{CHAR_BLK}};
    endcase
    return d;
  endfunction

  // ========================================
  // Checks and waits
  // ========================================
  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED t=%0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic wait_digit(input int pos, input code_t code, input int limit);
    int n;
    n = 0;
    while (seg_data[pos] !== code && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (seg_data[pos] === code) else begin
      errors++;
      $display("Timeout at %0t: display digit %0d never showed code %0d", $time, pos, code);
    end
  endtask

  task automatic wait_err(input logic level, input int limit, output int at);
    int n;
    n = 0;
    while (calc_err !== level && n < limit) begin
      @(negedge clk);
      n++;
    end
    at = cyc;
    assert (calc_err === level) else begin
      errors++;
      $display("Timeout at %0t: calc_err did not reach %0b", $time, level);
    end
  endtask

  // Compare each new ALU request with the oldest expectation
  always @(negedge clk) begin : compare_alu
    alu_exp_t e;
    if (rst_n) begin
      if (calc_err && !err_seen) err_rise_cyc = cyc;
      if (calc_sys_done) sys_done_count++;
      if (alu_req && !req_seen) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("Unexpected ALU request at %0t with op %0d", $time, alu_op_code);
        end
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          check_value("alu_op_code", 64'(alu_op_code), 64'(e.op));
          check_value("alu_id_a", 64'(alu_id_a), 64'(e.a));
          if (e.chk_b) check_value("alu_id_b", 64'(alu_id_b), 64'(e.b));
          if (e.chk_sc) check_value("alu_scalar", 64'(alu_scalar), 64'(e.sc));
        end
      end
    end
    req_seen = alu_req;
    err_seen = calc_err;
  end

  // ========================================
  // Stimulus helpers
  // ========================================
  task automatic send_byte(input logic [7:0] val);
    @(negedge clk);
    rx_data = val;
    rx_done = 1'b1;
    @(negedge clk);
    rx_done = 1'b0;
    repeat (3) @(negedge clk);  // State settles 2 clocks after rx_done
  endtask

  task automatic press_button(input logic esc);
    @(negedge clk);
    if (esc) btn_esc = 1'b1;
    else btn_confirm = 1'b1;
    repeat (2) @(negedge clk);
    btn_esc     = 1'b0;
    btn_confirm = 1'b0;
    repeat (3) @(negedge clk);
  endtask

  task automatic enter_op(input logic [7:0] letter, input op_code_t op, input mat_id_t ia,
                          input mat_id_t ib);
    send_byte(letter);
    send_byte({2'b00, ia});
    if (op == OP_ADD || op == OP_MAT_MUL) send_byte({2'b00, ib});  // Two-operand ops only
  endtask

  task automatic confirm_op(input op_code_t op, input mat_id_t ia, input mat_id_t ib,
                            input logic chk_b, input elem_t sc, input logic chk_sc);
    alu_exp_t e;
    e = '{op: op, a: ia, b: ib, chk_b: chk_b, sc: sc, chk_sc: chk_sc};
    if (ref_valid(op, ia, ib)) exp_q.push_back(e);
    press_button(1'b0);
  endtask

  // Waits for the cycle readout, checks it, then leaves DONE_WAIT
  task automatic finish_exec(input logic [31:0] cnt);
    wait_digit(4, CHAR_L, 60);
    check_value("seg_data", 64'(seg_data), 64'(ref_display(DISP_CYCLES, OP_NONE, '0, 8'h00, 0, cnt)));
    check_value("pending ALU requests", 64'(exp_q.size()), 64'd0);
    check_value("calc_err", 64'(calc_err), 64'd0);
    press_button(1'b0);
  endtask

  initial begin
    rst_n             = 1'b0;
    start_en          = 1'b0;
    btn_confirm       = 1'b0;
    btn_esc           = 1'b0;
    rx_data           = 8'h00;
    rx_done           = 1'b0;
    scalar_val_in     = 8'h00;
    cfg_err_countdown = 4'(CD_CFG);
    resp_err          = 1'b0;
    resp_cycles       = '0;
    repeat (16) @(negedge clk);
    check_value("alu_req", 64'(alu_req), 64'd0);
    check_value("calc_err", 64'(calc_err), 64'd0);
    check_value("calc_sys_done", 64'(calc_sys_done), 64'd0);
    check_value("seg_data", 64'(seg_data), 64'(ref_display(DISP_BLANK, OP_NONE, '0, 8'h00, 0, 0)));
    rst_n    = 1'b1;
    start_en = 1'b1;

    // Add, matching operands
    a = make_id(rand_below(4), rand_below(8));
    resp_cycles = $random(seed);
    enter_op("a", OP_ADD, a, a);
    confirm_op(OP_ADD, a, a, 1'b1, '0, 1'b0);
    finish_exec(resp_cycles);

    // Multiply mismatch, countdown runs out
    a = make_id(rand_below(4), rand_below(4));
    b = make_id((int'(a[2:0]) + 1) % 4, rand_below(8));
    enter_op("B", OP_MAT_MUL, a, b);
    confirm_op(OP_MAT_MUL, a, b, 1'b1, '0, 1'b0);
    wait_err(1'b1, 10, t);
    wait_digit(5, CHAR_E, 10);
    @(negedge clk);  // Count loads one clock after the error
    check_value("seg_data", 64'(seg_data), 64'(ref_display(DISP_ERR, OP_NONE, '0, 8'h00, CD_CFG, 0)));
    wait_err(1'b0, 120, t);
    checks++;
    assert (t - err_rise_cyc >= (CD_CFG + 1) * TICK && t - err_rise_cyc <= (CD_CFG + 1) * TICK + 4)
    else begin
      errors++;
      $display("CHECK FAILED t=%0t expiry cycles got %0d expected %0d", $time,
               t - err_rise_cyc, (CD_CFG + 1) * TICK);
    end

    // Mismatch, then a fitting B ID during the countdown
    a = make_id(rand_below(4), rand_below(4));
    b = make_id((int'(a[2:0]) + 1) % 4, rand_below(8));
    enter_op("b", OP_MAT_MUL, a, b);
    confirm_op(OP_MAT_MUL, a, b, 1'b1, '0, 1'b0);
    wait_err(1'b1, 10, t);
    b = make_id(int'(a[2:0]), rand_below(8));  // B rows now equal A cols
    resp_cycles = $random(seed);
    send_byte({2'b00, b});
    confirm_op(OP_MAT_MUL, a, b, 1'b1, '0, 1'b0);
    wait_err(1'b0, 10, t);
    finish_exec(resp_cycles);

    // Scalar with negative sign-magnitude value
    mag = 8'(1 + rand_below(127));
    scalar_val_in = 8'h80 | mag;
    a = make_id(rand_below(4), rand_below(8));
    resp_cycles = $random(seed);
    enter_op("C", OP_SCALAR_MUL, a, a);
    wait_digit(2, CHAR_DASH, 10);
    check_value("seg_data", 64'(seg_data),
                64'(ref_display(DISP_SCALAR, OP_NONE, a, scalar_val_in, 0, 0)));
    confirm_op(OP_SCALAR_MUL, a, a, 1'b0, ref_scalar(scalar_val_in), 1'b1);
    finish_exec(resp_cycles);

    // Convolution puts the kernel on both IDs; transpose ignores B
    a = make_id(rand_below(4), rand_below(8));
    resp_cycles = $random(seed);
    enter_op("j", OP_CONV, a, a);
    confirm_op(OP_CONV, a, a, 1'b1, '0, 1'b0);
    finish_exec(resp_cycles);
    a = make_id(rand_below(4), rand_below(8));
    resp_cycles = $random(seed);
    enter_op("T", OP_TRANSPOSE, a, a);
    confirm_op(OP_TRANSPOSE, a, a, 1'b0, '0, 1'b0);
    finish_exec(resp_cycles);

    // ALU reports an error, esc clears it
    resp_err = 1'b1;
    a = make_id(rand_below(4), rand_below(8));
    enter_op("A", OP_ADD, a, a);
    confirm_op(OP_ADD, a, a, 1'b1, '0, 1'b0);
    wait_err(1'b1, 60, t);
    press_button(1'b1);
    wait_err(1'b0, 10, t);
    wait_digit(5, CHAR_BLK, 10);
    check_value("seg_data", 64'(seg_data), 64'(ref_display(DISP_OP, OP_ADD, '0, 8'h00, 0, 0)));
    check_value("pending ALU requests", 64'(exp_q.size()), 64'd0);
    resp_err = 1'b0;

    // Esc in selection leaves calculator mode until start_en
    start_en = 1'b0;
    press_button(1'b1);
    check_value("calc_sys_done pulses", 64'(sys_done_count), 64'd1);
    a = make_id(rand_below(4), rand_below(8));
    enter_op("A", OP_ADD, a, a);
    press_button(1'b0);  // Ignored in IDLE, any request is flagged
    repeat (20) @(negedge clk);
    check_value("alu_req", 64'(alu_req), 64'd0);
    check_value("seg_data", 64'(seg_data), 64'(ref_display(DISP_BLANK, OP_NONE, '0, 8'h00, 0, 0)));
    start_en = 1'b1;
    resp_cycles = $random(seed);
    enter_op("A", OP_ADD, a, a);
    confirm_op(OP_ADD, a, a, 1'b1, '0, 1'b0);
    finish_exec(resp_cycles);
    check_value("calc_sys_done pulses", 64'(sys_done_count), 64'd1);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/calc_pkg.sv
logic/user_input_frontend.sv
logic/calc_sequencer.sv
logic/alu_link.sv
logic/err_countdown.sv
logic/seg_formatter.sv
logic/calc_ctrl_top.sv
test/alu_responder.sv
test/tb_calc_ctrl_top.sv

/* Makefile */
# Verilator flow for the calculator controller testbench

TOP = tb_calc_ctrl_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
